/* Makefile */
VERILATOR ?= verilator
TOP       := tb_quad_ctrl
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)

SRCS := $(shell grep -v '^+' $(FLIST)) sim/tb_quad_model.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/quad_ctrl_pkg.sv */
`default_nettype none

package quad_ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes

    // Quad BRAM depth sets the row and column index width
    localparam int BRAM_DEPTH      = 1024;
    localparam int LOG2_BRAM_DEPTH = $clog2(BRAM_DEPTH);

    localparam int PFB_COUNT_W     = 10;
    localparam int SEQ_ADDR_W      = 12;

    // Sequence reads per output column
    localparam int SEQ_CYCLES      = 6;
    localparam int CYCLE_W         = 3;

    // Input rows loaded before the first pass
    localparam int PRIME_ROWS      = 4;

    // Sequence BRAM read strobe to first CE execute
    localparam int SEQ_RD_LATENCY  = 3;

    localparam int NUM_AWE         = 4;
    localparam int NUM_CE_PER_AWE  = 2;
    localparam int NUM_CE          = NUM_AWE * NUM_CE_PER_AWE;

    ////////////////////////////////////////////////////////////////////////////
    // Types

    // One-hot job state
    typedef enum logic [5:0] {
        ST_IDLE      = 6'b000001,
        ST_PRIME     = 6'b000010,
        ST_FETCH     = 6'b000100,
        ST_ACTIVE    = 6'b001000,
        ST_WAIT_DONE = 6'b010000,
        ST_COMPLETE  = 6'b100000
    } quad_state_t;

    // Both fields are last indices, not counts
    typedef struct packed {
        logic [LOG2_BRAM_DEPTH-1:0] num_input_rows;
        logic [LOG2_BRAM_DEPTH-1:0] num_input_cols;
    } job_cfg_t;

    // Inputs from the fetch engine
    typedef struct packed {
        logic fetch_ack;
        logic fetch_done;
    } fetch_if_t;

    // End of pass flags from the sequence reader
    typedef struct packed {
        logic pass_end;
        logic row_done;
        logic job_done;
    } pass_status_t;

endpackage

`default_nettype wire

/* flist.f */
+incdir+sim
common/quad_ctrl_pkg.sv
quad_ctrl/quad_job_fsm.sv
hdl/pfb_reader.sv
hdl/pix_seq_reader.sv
hdl/ce_issue_chain.sv
hdl/quad_ctrl_top.sv
sim/tb_quad_ctrl.sv

/* hdl/ce_issue_chain.sv */
`timescale 1ns/1ns
`default_nettype none

module ce_issue_chain #(
    parameter int NUM_CE         = quad_ctrl_pkg::NUM_CE,
    parameter int SEQ_RD_LATENCY = quad_ctrl_pkg::SEQ_RD_LATENCY
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              pix_seq_rden,
    input  logic              pass_end,
    output logic [NUM_CE-1:0] ce_execute,
    output logic [NUM_CE-1:0] next_kernel
);

    // BRAM latency stages and the CE stages share one shift register
    localparam int EXEC_LEN = SEQ_RD_LATENCY + NUM_CE - 1;

    logic [EXEC_LEN-1:0] exec_sr;

    // Tap k holds the read strobe from k+1 cycles back
    assign ce_execute = exec_sr[EXEC_LEN-1:SEQ_RD_LATENCY-1];

    ////////////////////////////////////////////////////////////////////////////
    // Execute and next-kernel chains, one CE per cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_sr     <= '0;
            next_kernel <= '0;
        end else begin
            exec_sr[0] <= pix_seq_rden;
            for (int i = 1; i < EXEC_LEN; i++) begin
                exec_sr[i] <= exec_sr[i-1];
            end

            // Kernel switch trails the final read of each pass
            next_kernel[0] <= pass_end;
            for (int i = 1; i < NUM_CE; i++) begin
                next_kernel[i] <= next_kernel[i-1];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/pfb_reader.sv */
`timescale 1ns/1ns
`default_nettype none

module pfb_reader (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     rows_owed_en,
    input  logic                                     pfb_empty,
    input  quad_ctrl_pkg::fetch_if_t                 fetch,
    input  logic [quad_ctrl_pkg::PFB_COUNT_W-1:0]    pfb_full_count,
    input  quad_ctrl_pkg::job_cfg_t                  job_cfg,
    input  logic                                     pass_start,
    input  logic                                     counters_clear,
    output logic                                     pfb_rden,
    output logic                                     count_zero,
    output logic [2:0]                               rows_read,
    output logic [quad_ctrl_pkg::LOG2_BRAM_DEPTH-1:0] input_row,
    output logic [quad_ctrl_pkg::LOG2_BRAM_DEPTH-1:0] input_col
);
    import quad_ctrl_pkg::*;

    // Pixels left in the prefetch buffer
    logic [PFB_COUNT_W-1:0] pfb_count;
    logic                   fetch_pending;
    logic                   row_end;

    assign count_zero = (pfb_count == '0);
    assign row_end    = (input_col == job_cfg.num_input_cols);

    // One pixel per cycle, stalled by back-pressure
    assign pfb_rden = rows_owed_en && !count_zero && !pfb_empty;

    ////////////////////////////////////////////////////////////////////////////
    // Buffer fill level

    always_ff @(posedge clk) begin
        if (rst || counters_clear) begin
            pfb_count     <= '0;
            fetch_pending <= 1'b0;
        end else begin
            // Open from ack to done
            if (fetch.fetch_ack) begin
                fetch_pending <= 1'b1;
            end
            if (fetch.fetch_done) begin
                fetch_pending <= 1'b0;
            end
            if (fetch.fetch_done && fetch_pending) begin
                pfb_count <= pfb_full_count;
            end else if (pfb_rden) begin
                pfb_count <= pfb_count - 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Input position

    always_ff @(posedge clk) begin
        if (rst || counters_clear) begin
            input_row <= '0;
            input_col <= '0;
            rows_read <= '0;
        end else begin
            // Each refill counts its rows from zero
            if (pass_start) begin
                rows_read <= '0;
            end
            if (pfb_rden) begin
                if (row_end) begin
                    input_col <= '0;
                    input_row <= input_row + 1'b1;
                    rows_read <= rows_read + 1'b1;
                end else begin
                    input_col <= input_col + 1'b1;
                end
            end
        end
    end

    // Empty flag comes from outside, reads must respect it
    assert property (@(posedge clk) disable iff (rst) pfb_empty |-> !pfb_rden);

endmodule

`default_nettype wire

/* hdl/pix_seq_reader.sv */
`timescale 1ns/1ns
`default_nettype none

module pix_seq_reader #(
    parameter int SEQ_CYCLES = quad_ctrl_pkg::SEQ_CYCLES
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  seq_active,
    input  logic                                  pass_start,
    input  logic                                  last_kernel,
    input  quad_ctrl_pkg::job_cfg_t               job_cfg,
    input  logic                                  counters_clear,
    output logic                                  pix_seq_rden,
    output logic [quad_ctrl_pkg::SEQ_ADDR_W-1:0]  pix_seq_addr,
    output quad_ctrl_pkg::pass_status_t           pass_status
);
    import quad_ctrl_pkg::*;

    // Widen the cycle counter only for longer sequences
    localparam int CNT_W = ($clog2(SEQ_CYCLES) > CYCLE_W) ? $clog2(SEQ_CYCLES) : CYCLE_W;
    localparam logic [CNT_W-1:0] LAST_CYCLE = CNT_W'(SEQ_CYCLES - 1);

    // Final output row index is rows minus PRIME_ROWS plus one
    localparam logic [LOG2_BRAM_DEPTH-1:0] ROW_OFFSET = LOG2_BRAM_DEPTH'(PRIME_ROWS - 1);

    logic [CNT_W-1:0]           cycle_cnt;
    logic [LOG2_BRAM_DEPTH-1:0] out_col;
    logic [LOG2_BRAM_DEPTH-1:0] out_row;
    logic                       col_end;
    logic                       last_row;
    logic                       pass_end;

    ////////////////////////////////////////////////////////////////////////////
    // Pass end decode

    assign col_end  = (cycle_cnt == LAST_CYCLE);
    assign pass_end = pix_seq_rden && col_end && (out_col == job_cfg.num_input_cols);
    assign last_row = (out_row == job_cfg.num_input_rows - ROW_OFFSET);

    // last_kernel sampled together with the final read of the pass
    assign pass_status = '{
        pass_end: pass_end,
        row_done: pass_end && last_kernel && !last_row,
        job_done: pass_end && last_kernel && last_row
    };

    ////////////////////////////////////////////////////////////////////////////
    // Read strobe, address and position

    always_ff @(posedge clk) begin
        if (rst || counters_clear) begin
            pix_seq_rden <= 1'b0;
            pix_seq_addr <= '0;
            cycle_cnt    <= '0;
            out_col      <= '0;
            out_row      <= '0;
        end else begin
            // No gaps inside a pass
            pix_seq_rden <= pass_start || (pix_seq_rden && seq_active && !pass_end);

            // Every pass walks the sequence from address zero
            if (pass_start) begin
                pix_seq_addr <= '0;
            end else if (pix_seq_rden) begin
                pix_seq_addr <= pix_seq_addr + 1'b1;
            end

            if (pix_seq_rden) begin
                if (col_end) begin
                    cycle_cnt <= '0;
                    if (out_col == job_cfg.num_input_cols) begin
                        out_col <= '0;
                    end else begin
                        out_col <= out_col + 1'b1;
                    end
                end else begin
                    cycle_cnt <= cycle_cnt + 1'b1;
                end
            end

            // Row moves only once the last kernel has run
            if (pass_end && last_kernel) begin
                out_row <= out_row + 1'b1;
            end
        end
    end

    // Wrap keeps the counter inside one output column
    assert property (@(posedge clk) disable iff (rst) cycle_cnt <= LAST_CYCLE);

endmodule

`default_nettype wire

/* hdl/quad_ctrl_top.sv */
`timescale 1ns/1ns
`default_nettype none

module quad_ctrl_top #(
    parameter int NUM_CE     = quad_ctrl_pkg::NUM_CE,
    parameter int SEQ_CYCLES = quad_ctrl_pkg::SEQ_CYCLES
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  quad_ctrl_pkg::job_cfg_t                   job_cfg,
    input  logic                                      job_start,
    input  quad_ctrl_pkg::fetch_if_t                  fetch,
    input  logic [quad_ctrl_pkg::PFB_COUNT_W-1:0]     pfb_full_count,
    input  logic                                      pfb_empty,
    input  logic                                      last_kernel,
    input  logic                                      pipeline_flushed,
    input  logic                                      job_complete_ack,
    output logic                                      job_accept,
    output logic                                      fetch_req,
    output logic                                      job_complete,
    output logic                                      pfb_rden,
    output logic [quad_ctrl_pkg::LOG2_BRAM_DEPTH-1:0] input_row,
    output logic [quad_ctrl_pkg::LOG2_BRAM_DEPTH-1:0] input_col,
    output logic                                      pix_seq_rden,
    output logic [quad_ctrl_pkg::SEQ_ADDR_W-1:0]      pix_seq_addr,
    output logic [NUM_CE-1:0]                         ce_execute,
    output logic [NUM_CE-1:0]                         next_kernel,
    output quad_ctrl_pkg::quad_state_t                state
);
    import quad_ctrl_pkg::*;

    // FSM to readers
    logic         rows_owed_en;
    logic         pass_start;
    logic         seq_active;
    logic         counters_clear;

    // Readers back to FSM
    logic         count_zero;
    logic [2:0]   rows_read;
    pass_status_t pass_status;

    ////////////////////////////////////////////////////////////////////////////
    // Job sequencing

    quad_job_fsm u_fsm (
        .clk              (clk),
        .rst              (rst),
        .job_start        (job_start),
        .job_cfg          (job_cfg),
        .fetch            (fetch),
        .count_zero       (count_zero),
        .rows_read        (rows_read),
        .pass_status      (pass_status),
        .pipeline_flushed (pipeline_flushed),
        .job_complete_ack (job_complete_ack),
        .job_accept       (job_accept),
        .fetch_req        (fetch_req),
        .job_complete     (job_complete),
        .rows_owed_en     (rows_owed_en),
        .pass_start       (pass_start),
        .seq_active       (seq_active),
        .counters_clear   (counters_clear),
        .state            (state)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Readers and CE chain

    pfb_reader u_pfb (
        .clk            (clk),
        .rst            (rst),
        .rows_owed_en   (rows_owed_en),
        .pfb_empty      (pfb_empty),
        .fetch          (fetch),
        .pfb_full_count (pfb_full_count),
        .job_cfg        (job_cfg),
        .pass_start     (pass_start),
        .counters_clear (counters_clear),
        .pfb_rden       (pfb_rden),
        .count_zero     (count_zero),
        .rows_read      (rows_read),
        .input_row      (input_row),
        .input_col      (input_col)
    );

    pix_seq_reader #(
        .SEQ_CYCLES (SEQ_CYCLES)
    ) u_seq (
        .clk            (clk),
        .rst            (rst),
        .seq_active     (seq_active),
        .pass_start     (pass_start),
        .last_kernel    (last_kernel),
        .job_cfg        (job_cfg),
        .counters_clear (counters_clear),
        .pix_seq_rden   (pix_seq_rden),
        .pix_seq_addr   (pix_seq_addr),
        .pass_status    (pass_status)
    );

    // Execute delay tracks the sequence BRAM read latency
    ce_issue_chain #(
        .NUM_CE         (NUM_CE),
        .SEQ_RD_LATENCY (SEQ_RD_LATENCY)
    ) u_chain (
        .clk          (clk),
        .rst          (rst),
        .pix_seq_rden (pix_seq_rden),
        .pass_end     (pass_status.pass_end),
        .ce_execute   (ce_execute),
        .next_kernel  (next_kernel)
    );

endmodule

`default_nettype wire

/* quad_ctrl/quad_job_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module quad_job_fsm (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        job_start,
    input  quad_ctrl_pkg::job_cfg_t     job_cfg,
    input  quad_ctrl_pkg::fetch_if_t    fetch,
    input  logic                        count_zero,
    input  logic [2:0]                  rows_read,
    input  quad_ctrl_pkg::pass_status_t pass_status,
    input  logic                        pipeline_flushed,
    input  logic                        job_complete_ack,
    output logic                        job_accept,
    output logic                        fetch_req,
    output logic                        job_complete,
    output logic                        rows_owed_en,
    output logic                        pass_start,
    output logic                        seq_active,
    output logic                        counters_clear,
    output quad_ctrl_pkg::quad_state_t  state
);
    import quad_ctrl_pkg::*;

    quad_state_t return_state;
    logic        refill;
    logic        fetch_acked;
    logic [2:0]  rows_target;
    logic        rows_done;

    ////////////////////////////////////////////////////////////////////////////
    // Row loading status

    // Priming wants PRIME_ROWS rows, a refill just one
    assign rows_target = refill ? 3'd1 : 3'(PRIME_ROWS);
    assign rows_done   = (rows_read == rows_target);

    // Reader may pull pixels only while rows are still owed
    assign rows_owed_en = (state == ST_PRIME) && !rows_done;
    assign seq_active   = (state == ST_ACTIVE);

    // First pass after loading, or a repeat pass for the next kernel
    assign pass_start = ((state == ST_PRIME) && rows_done) ||
                        (seq_active && pass_status.pass_end &&
                         !pass_status.row_done && !pass_status.job_done);

    // Job done and acked
    assign counters_clear = (state == ST_COMPLETE) && job_complete_ack;

    ////////////////////////////////////////////////////////////////////////////
    // State machine

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= ST_IDLE;
            return_state <= ST_IDLE;
            refill       <= 1'b0;
            fetch_acked  <= 1'b0;
            job_accept   <= 1'b0;
            fetch_req    <= 1'b0;
            job_complete <= 1'b0;
        end else begin
            // Single cycle pulse
            job_accept <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        refill     <= 1'b0;
                        state      <= ST_PRIME;
                    end
                end
                ST_PRIME: begin
                    if (rows_done) begin
                        state <= ST_ACTIVE;
                    end else if (count_zero) begin
                        // Buffer drained with rows still owed
                        return_state <= state;
                        state        <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    // Request up until the engine acks it
                    if (fetch.fetch_ack) begin
                        fetch_req   <= 1'b0;
                        fetch_acked <= 1'b1;
                    end else if (!fetch_acked) begin
                        fetch_req <= 1'b1;
                    end
                    // Buffer count reloads on this same edge
                    if (fetch.fetch_done) begin
                        fetch_acked <= 1'b0;
                        state       <= return_state;
                    end
                end
                ST_ACTIVE: begin
                    if (pass_status.job_done) begin
                        state <= ST_WAIT_DONE;
                    end else if (pass_status.row_done) begin
                        // Output row moved down, pull one fresh input row
                        refill <= 1'b1;
                        state  <= ST_PRIME;
                    end
                end
                ST_WAIT_DONE: begin
                    if (pipeline_flushed) begin
                        job_complete <= 1'b1;
                        state        <= ST_COMPLETE;
                    end
                end
                ST_COMPLETE: begin
                    if (job_complete_ack) begin
                        job_complete <= 1'b0;
                        state        <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks

    // Encoding stays one-hot
    assert property (@(posedge clk) disable iff (rst) $onehot(state));

    // Job sizes held by the host from accept through complete ack
    assert property (@(posedge clk) disable iff (rst)
        (state != ST_IDLE) |-> $stable(job_cfg));

endmodule

`default_nettype wire

/* sim/tb_quad_model.svh */
`ifndef TB_QUAD_MODEL_SVH
`define TB_QUAD_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Reference model state

// Expected position of the next PFB read
int exp_row;
int exp_col;

// Per job event counts
int pfb_reads;
int fetch_reqs;
int kernel_passes;

// Pixels the PFB should still hold
int pix_left;

// Read index inside the current pass
int seq_idx;

logic flushed_seen;
logic req_q = 1'b0;
logic ack_q = 1'b0;

// Bit j holds the value from j+1 cycles back
logic [31:0] rden_hist = '0;
logic [31:0] kern_hist = '0;

task automatic reset_model();
    exp_row       = 0;
    exp_col       = 0;
    pfb_reads     = 0;
    fetch_reqs    = 0;
    kernel_passes = 0;
    pix_left      = 0;
    seq_idx       = 0;
    flushed_seen  = 1'b0;
endtask

////////////////////////////////////////////////////////////////////////////
// Per cycle update, sampled just before the rising edge

task automatic update_model();
    int   cols;
    int   pass_len;
    logic pass_end;
    cols     = int'(job_cfg.num_input_cols);
    pass_len = (cols + 1) * SEQ_CYCLES;
    pass_end = 1'b0;

    // PFB reads walk the input rows with a column wrap
    if (pfb_empty) begin
        check_value(T_PFB, "read under pfb_empty", 0, pfb_rden);
    end
    if (pfb_rden) begin
        check_value(T_PFB, "input_row", exp_row, input_row);
        check_value(T_PFB, "input_col", exp_col, input_col);
        check_value(T_FETCH, "read with empty buffer", 1, pix_left != 0);
        pfb_reads++;
        pix_left--;
        if (exp_col == cols) begin
            exp_col = 0;
            exp_row++;
        end else begin
            exp_col++;
        end
    end
    // Buffer refilled on the done pulse
    if (fetch.fetch_done) begin
        pix_left = int'(pfb_full_count);
    end

    // Request counted on its rising edge, gone one cycle after ack
    if (fetch_req && !req_q) begin
        fetch_reqs++;
    end
    if (ack_q) begin
        check_value(T_FETCH, "fetch_req after ack", 0, fetch_req);
    end
    req_q = fetch_req;
    ack_q = fetch.fetch_ack;

    // Contiguous passes, address equals read index
    if (pix_seq_rden) begin
        check_value(T_SEQ, "pix_seq_addr", seq_idx, pix_seq_addr);
        if (seq_idx == pass_len - 1) begin
            pass_end = 1'b1;
            seq_idx  = 0;
            if (last_kernel) begin
                kernel_passes++;
            end
        end else begin
            seq_idx++;
        end
    end else if (seq_idx != 0) begin
        check_value(T_SEQ, "read gap inside pass", 1, 0);
        seq_idx = 0;
    end

    // CE chains against delayed history
    for (int i = 0; i < NUM_CE; i++) begin
        check_value(T_CHAIN, "ce_execute", rden_hist[SEQ_RD_LATENCY + i - 1], ce_execute[i]);
        check_value(T_CHAIN, "next_kernel", kern_hist[i], next_kernel[i]);
    end
    rden_hist = {rden_hist[30:0], pix_seq_rden};
    kern_hist = {kern_hist[30:0], pass_end};

    if (pipeline_flushed) begin
        flushed_seen = 1'b1;
    end
    if (job_complete) begin
        check_value(T_DONE, "job_complete before flush", 1, flushed_seen);
    end
endtask

task automatic check_job_totals();
    int rows;
    int total;
    int full;
    rows  = int'(job_cfg.num_input_rows);
    total = (rows + 1) * (int'(job_cfg.num_input_cols) + 1);
    full  = int'(pfb_full_count);
    check_value(T_PFB, "PFB reads per job", total, pfb_reads);
    check_value(T_FETCH, "fetch requests per job", (total + full - 1) / full, fetch_reqs);
    check_value(T_SEQ, "last kernel passes", rows - PRIME_ROWS + 2, kernel_passes);
endtask

`endif

/* sim/tb_quad_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_quad_ctrl;
    import quad_ctrl_pkg::*;

    localparam int JOB_TIMEOUT   = 50000;
    localparam int SHORT_TIMEOUT = 32;
    localparam int NUM_TESTS     = 6;
    localparam int T_HS    = 0;
    localparam int T_PFB   = 1;
    localparam int T_FETCH = 2;
    localparam int T_SEQ   = 3;
    localparam int T_CHAIN = 4;
    localparam int T_DONE  = 5;

    logic                       clk;
    logic                       rst;
    job_cfg_t                   job_cfg;
    logic                       job_start;
    fetch_if_t                  fetch;
    logic [PFB_COUNT_W-1:0]     pfb_full_count;
    logic                       pfb_empty;
    logic                       last_kernel;
    logic                       pipeline_flushed;
    logic                       job_complete_ack;
    logic                       job_accept;
    logic                       fetch_req;
    logic                       job_complete;
    logic                       pfb_rden;
    logic [LOG2_BRAM_DEPTH-1:0] input_row;
    logic [LOG2_BRAM_DEPTH-1:0] input_col;
    logic                       pix_seq_rden;
    logic [SEQ_ADDR_W-1:0]      pix_seq_addr;
    logic [NUM_CE-1:0]          ce_execute;
    logic [NUM_CE-1:0]          next_kernel;
    quad_state_t                state;

    // Values for the next falling edge
    logic                   rst_req;
    logic                   start_req;
    logic                   flush_req;
    logic                   ack_req;
    job_cfg_t               cfg_req;
    logic [PFB_COUNT_W-1:0] full_req;

    logic [31:0] lfsr;
    int          resp_phase;
    int          resp_wait;
    logic        timed_out;
    int          checks [NUM_TESTS];
    int          errors [NUM_TESTS];
    string       test_names [NUM_TESTS] = '{"job handshake", "PFB reading", "fetch handshake",
                                            "sequence passes", "CE chain", "completion"};

    quad_ctrl_top UUT (
        .clk              (clk),
        .rst              (rst),
        .job_cfg          (job_cfg),
        .job_start        (job_start),
        .fetch            (fetch),
        .pfb_full_count   (pfb_full_count),
        .pfb_empty        (pfb_empty),
        .last_kernel      (last_kernel),
        .pipeline_flushed (pipeline_flushed),
        .job_complete_ack (job_complete_ack),
        .job_accept       (job_accept),
        .fetch_req        (fetch_req),
        .job_complete     (job_complete),
        .pfb_rden         (pfb_rden),
        .input_row        (input_row),
        .input_col        (input_col),
        .pix_seq_rden     (pix_seq_rden),
        .pix_seq_addr     (pix_seq_addr),
        .ce_execute       (ce_execute),
        .next_kernel      (next_kernel),
        .state            (state)
    );

    // 100 ns period
    always #50 clk = ~clk;

    task automatic check_value(input int t, input string what, input int expected,
                               input int actual);
        checks[t]++;
        if (expected != actual) begin
            errors[t]++;
            $display("[ERROR] %s: %s expected %0d actual %0d", test_names[t], what,
                     expected, actual);
        end
    endtask

    `include "tb_quad_model.svh"

    ////////////////////////////////////////////////////////////////////////////
    // Random source

    // Galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] cur);
        return cur[0] ? ((cur >> 1) ^ 32'h80200003) : (cur >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int b = 0; b < n; b++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Fetch engine acks each request and pulses done some cycles later

    task automatic respond_fetch();
        fetch.fetch_ack  = 1'b0;
        fetch.fetch_done = 1'b0;
        case (resp_phase)
            0: begin
                if (fetch_req) begin
                    resp_wait  = rand_bits(2);
                    resp_phase = 1;
                end
            end
            1: begin
                if (resp_wait == 0) begin
                    fetch.fetch_ack = 1'b1;
                    resp_wait       = rand_bits(2);
                    resp_phase      = 2;
                end else begin
                    resp_wait--;
                end
            end
            default: begin
                // Done never shares a cycle with the ack
                if (resp_wait == 0) begin
                    fetch.fetch_done = 1'b1;
                    resp_phase       = 0;
                end else begin
                    resp_wait--;
                end
            end
        endcase
    endtask

    // Drive on the falling edge and sample once everything has settled
    task automatic tick();
        @(negedge clk);
        rst              = rst_req;
        job_start        = start_req;
        pipeline_flushed = flush_req;
        job_complete_ack = ack_req;
        job_cfg          = cfg_req;
        pfb_full_count   = full_req;
        start_req        = 1'b0;
        flush_req        = 1'b0;
        ack_req          = 1'b0;
        pfb_empty        = (rand_bits(2) == 3);
        last_kernel      = rand_bits(1) != 0;
        respond_fetch();
        #1;
        if (!rst) begin
            update_model();
        end
    endtask

    task automatic wait_state(input quad_state_t target, input int limit, input string what);
        int cnt;
        cnt = 0;
        while (state != target && !timed_out) begin
            if (cnt == limit) begin
                $display("Timeout: the DUT never reached %s within %0d cycles", what, limit);
                timed_out = 1'b1;
            end else begin
                tick();
                cnt++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One job from start to complete ack

    task automatic run_job();
        int delay;
        cfg_req.num_input_rows = LOG2_BRAM_DEPTH'(4 + rand_bits(3) % 6);
        cfg_req.num_input_cols = LOG2_BRAM_DEPTH'(1 + rand_bits(3) % 7);
        full_req               = PFB_COUNT_W'(3 + rand_bits(5) % 18);
        reset_model();
        start_req = 1'b1;
        tick();
        tick();
        check_value(T_HS, "job_accept after start", 1, job_accept);
        tick();
        check_value(T_HS, "job_accept width", 0, job_accept);
        check_value(T_HS, "state left idle", 1, state != ST_IDLE);

        wait_state(ST_WAIT_DONE, JOB_TIMEOUT, "the flush wait");
        if (timed_out) begin
            return;
        end
        delay = rand_bits(3);
        repeat (delay) begin
            tick();
            check_value(T_DONE, "job_complete before flush", 0, job_complete);
        end
        flush_req = 1'b1;
        tick();
        wait_state(ST_COMPLETE, SHORT_TIMEOUT, "the complete state");
        if (timed_out) begin
            return;
        end
        check_value(T_DONE, "job_complete raised", 1, job_complete);

        // Held until the host acks
        delay = rand_bits(3);
        repeat (delay) begin
            tick();
            check_value(T_DONE, "job_complete held", 1, job_complete);
        end
        ack_req = 1'b1;
        tick();
        wait_state(ST_IDLE, SHORT_TIMEOUT, "idle after the ack");
        if (timed_out) begin
            return;
        end
        check_value(T_DONE, "job_complete after ack", 0, job_complete);
        check_value(T_DONE, "input_row cleared", 0, input_row);
        check_value(T_DONE, "input_col cleared", 0, input_col);
        check_job_totals();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        int total_checks;
        int total_errors;
        clk              = 1'b0;
        rst              = 1'b1;
        job_cfg          = '0;
        job_start        = 1'b0;
        fetch            = '0;
        pfb_full_count   = '0;
        pfb_empty        = 1'b0;
        last_kernel      = 1'b0;
        pipeline_flushed = 1'b0;
        job_complete_ack = 1'b0;
        rst_req          = 1'b1;
        start_req        = 1'b0;
        flush_req        = 1'b0;
        ack_req          = 1'b0;
        cfg_req          = '0;
        full_req         = '0;
        lfsr             = 32'h49db6e7a;
        resp_phase       = 0;
        resp_wait        = 0;
        timed_out        = 1'b0;
        total_checks     = 0;
        total_errors     = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end
        reset_model();

        // Reset spans four rising edges starting at 50 ns
        repeat (3) tick();
        rst_req = 1'b0;
        tick();
        // Quiet outputs out of reset
        check_value(T_HS, "job_accept after reset", 0, job_accept);
        check_value(T_HS, "fetch_req after reset", 0, fetch_req);
        check_value(T_HS, "job_complete after reset", 0, job_complete);
        check_value(T_HS, "pfb_rden after reset", 0, pfb_rden);
        check_value(T_HS, "pix_seq_rden after reset", 0, pix_seq_rden);
        check_value(T_HS, "ce_execute after reset", 0, ce_execute);
        check_value(T_HS, "next_kernel after reset", 0, next_kernel);
        check_value(T_HS, "state after reset", ST_IDLE, state);

        // Three jobs back to back
        for (int j = 0; j < 3 && !timed_out; j++) begin
            run_job();
        end

        for (int t = 0; t < NUM_TESTS; t++) begin
            $display("%s: %0d checks, %0d errors", test_names[t], checks[t], errors[t]);
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("Totals: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
